// ==== hdl/orange_vision_pkg.sv ====
package orange_vision_pkg;

    // One RGB444 colour channel
    typedef logic [3:0] color_t;

    // Steering result reported once per complete row
    typedef enum logic [2:0] {
        DIR_NONE   = 3'd0,
        DIR_LEFT   = 3'd1,
        DIR_RIGHT  = 3'd2,
        DIR_CENTER = 3'd3
    } direction_t;

    // Width of the column and row counters
    localparam int COORD_W = 10;

    // Orange box in RGB444 space
    // Strong red, moderate green, very little blue
    localparam color_t ORANGE_RED_MIN   = 4'd12;
    localparam color_t ORANGE_GREEN_MIN = 4'd4;
    localparam color_t ORANGE_GREEN_MAX = 4'd9;  // Above this it turns yellow
    localparam color_t ORANGE_BLUE_MAX  = 4'd3;

endpackage

// ==== hdl/pixel_stream_if.sv ====
`timescale 1ns/10ps

// Tagged pixel passed between pipeline stages, one strobe per pixel
interface pixel_stream_if;

    logic                                 valid;
    orange_vision_pkg::color_t            red;
    orange_vision_pkg::color_t            green;
    orange_vision_pkg::color_t            blue;
    logic [orange_vision_pkg::COORD_W-1:0] col;
    logic                                 is_orange;
    logic                                 line_end;   // Last pixel of a complete row
    logic                                 frame_end;  // Last pixel of the last row

    modport source (
        output valid, red, green, blue, col, is_orange, line_end, frame_end
    );

    modport sink (
        input valid, red, green, blue, col, is_orange, line_end, frame_end
    );

endinterface

// ==== hdl/raster_tracker.sv ====
`timescale 1ns/10ps

module raster_tracker #(
    parameter int FRAME_WIDTH  = 320,
    parameter int FRAME_HEIGHT = 240
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      vsync,
    input  logic                      href,
    input  orange_vision_pkg::color_t red,
    input  orange_vision_pkg::color_t green,
    input  orange_vision_pkg::color_t blue,
    pixel_stream_if.source            px
);

    localparam int CW = orange_vision_pkg::COORD_W;
    localparam logic [CW-1:0] LAST_COL = CW'(FRAME_WIDTH - 1);
    localparam logic [CW-1:0] LAST_ROW = CW'(FRAME_HEIGHT - 1);

    logic                      vsync_q;
    logic                      href_q;
    orange_vision_pkg::color_t red_q;
    orange_vision_pkg::color_t green_q;
    orange_vision_pkg::color_t blue_q;

    logic [CW-1:0] col_cnt;
    logic [CW-1:0] row_cnt;
    logic          overrun;      // Row width reached, extra pixels dropped until href falls
    logic          accept;
    logic          at_line_end;

    assign accept      = href_q && !vsync_q && !overrun;
    assign at_line_end = (col_cnt == LAST_COL);

    // Camera input register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vsync_q <= 1'b0;
            href_q  <= 1'b0;
        end else begin
            vsync_q <= vsync;
            href_q  <= href;
        end
    end

    always_ff @(posedge clk) begin
        red_q   <= red;
        green_q <= green;
        blue_q  <= blue;
    end

    // Column and row position
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
            overrun <= 1'b0;
        end else if (vsync_q) begin
            col_cnt <= '0;  // New frame
            row_cnt <= '0;
            overrun <= 1'b0;
        end else if (!href_q) begin
            col_cnt <= '0;  // Blanking, a partial row is abandoned
            overrun <= 1'b0;
        end else if (accept) begin
            if (at_line_end) begin
                col_cnt <= '0;
                overrun <= 1'b1;
                row_cnt <= (row_cnt == LAST_ROW) ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // Output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            px.valid <= 1'b0;
        end else begin
            px.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            px.red       <= red_q;
            px.green     <= green_q;
            px.blue      <= blue_q;
            px.col       <= col_cnt;
            px.line_end  <= at_line_end;
            px.frame_end <= at_line_end && (row_cnt == LAST_ROW);
        end
    end

    assign px.is_orange = 1'b0;  // Filled in by the colour detector

    a_col_in_row: assert property (@(posedge clk) disable iff (!rst_n)
        px.valid |-> (px.col < CW'(FRAME_WIDTH)));

endmodule

// ==== hdl/orange_color_detect.sv ====
`timescale 1ns/10ps

module orange_color_detect (
    input  logic           clk,
    input  logic           rst_n,
    pixel_stream_if.sink   in_px,
    pixel_stream_if.source out_px
);

    logic red_ok;
    logic green_ok;
    logic blue_ok;
    logic hit;

    // Threshold box test
    assign red_ok   = (in_px.red >= orange_vision_pkg::ORANGE_RED_MIN);
    assign green_ok = (in_px.green >= orange_vision_pkg::ORANGE_GREEN_MIN)
                   && (in_px.green <= orange_vision_pkg::ORANGE_GREEN_MAX);
    assign blue_ok  = (in_px.blue <= orange_vision_pkg::ORANGE_BLUE_MAX);
    assign hit      = red_ok && green_ok && blue_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_px.valid <= 1'b0;
        end else begin
            out_px.valid <= in_px.valid;
        end
    end

    // Pixel payload moves on with its decision attached
    always_ff @(posedge clk) begin
        if (in_px.valid) begin
            out_px.red       <= in_px.red;
            out_px.green     <= in_px.green;
            out_px.blue      <= in_px.blue;
            out_px.col       <= in_px.col;
            out_px.line_end  <= in_px.line_end;
            out_px.frame_end <= in_px.frame_end;
            out_px.is_orange <= hit;
        end
    end

    // One output pixel per input pixel, exactly one cycle later
    a_one_stage: assert property (@(posedge clk) disable iff (!rst_n)
        out_px.valid |-> $past(in_px.valid));

endmodule

// ==== hdl/orange_classification.sv ====
`timescale 1ns/10ps

module orange_classification #(
    parameter int FRAME_WIDTH  = 320,
    parameter int FRAME_HEIGHT = 240,
    parameter int LEFT_END     = 100,
    parameter int RIGHT_START  = 295,
    parameter int COVERAGE_PCT = 25
) (
    input  logic                          clk,
    input  logic                          rst_n,
    pixel_stream_if.sink                  px,
    output orange_vision_pkg::direction_t direction,
    output logic                          direction_valid,
    output logic                          orange_detected,
    output logic                          coverage_valid
);

    localparam int CW     = orange_vision_pkg::COORD_W;
    localparam int CNT_W  = $clog2(FRAME_WIDTH + 1);
    localparam int TOT_W  = $clog2(FRAME_WIDTH * FRAME_HEIGHT + 1);
    localparam int PROD_W = TOT_W + 7;  // Room for the total times 100
    localparam logic [PROD_W-1:0] COVER_LIMIT =
        PROD_W'(COVERAGE_PCT * FRAME_WIDTH * FRAME_HEIGHT);

    logic [CNT_W-1:0] left_cnt;
    logic [CNT_W-1:0] center_cnt;
    logic [CNT_W-1:0] right_cnt;
    logic [TOT_W-1:0] total_cnt;

    logic [CNT_W-1:0] left_next;
    logic [CNT_W-1:0] center_next;
    logic [CNT_W-1:0] right_next;
    logic [TOT_W-1:0] total_next;
    logic [PROD_W-1:0] total_scaled;

    logic row_start;
    logic hit;
    logic in_left;
    logic in_center;
    logic in_right;
    orange_vision_pkg::direction_t dir_next;

    assign hit       = px.valid && px.is_orange;
    assign row_start = (px.col == '0);  // Also drops counts left over from a partial row
    assign in_left   = (px.col < CW'(LEFT_END));
    assign in_center = !in_left && (px.col < CW'(RIGHT_START));
    assign in_right  = !in_left && !in_center;

    // Counts including the current pixel
    assign left_next   = (row_start ? '0 : left_cnt) + CNT_W'(hit && in_left);
    assign center_next = (row_start ? '0 : center_cnt) + CNT_W'(hit && in_center);
    assign right_next  = (row_start ? '0 : right_cnt) + CNT_W'(hit && in_right);
    assign total_next  = total_cnt + TOT_W'(hit);

    assign total_scaled = PROD_W'(total_next) * PROD_W'(100);

    // Ordered steering rule, right wins ties against nothing
    always_comb begin
        if (right_next > left_next) begin
            dir_next = orange_vision_pkg::DIR_RIGHT;
        end else if ((center_next > left_next) && (center_next > right_next)) begin
            dir_next = orange_vision_pkg::DIR_CENTER;
        end else if (left_next > right_next) begin
            dir_next = orange_vision_pkg::DIR_LEFT;
        end else begin
            dir_next = orange_vision_pkg::DIR_NONE;
        end
    end

    // Zone and frame counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            left_cnt   <= '0;
            center_cnt <= '0;
            right_cnt  <= '0;
            total_cnt  <= '0;
        end else if (px.valid) begin
            if (px.line_end) begin
                left_cnt   <= '0;
                center_cnt <= '0;
                right_cnt  <= '0;
            end else begin
                left_cnt   <= left_next;
                center_cnt <= center_next;
                right_cnt  <= right_next;
            end
            // Total runs from one frame end to the next, partial rows included
            total_cnt <= px.frame_end ? '0 : total_next;
        end
    end

    // Results, held between strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            direction       <= orange_vision_pkg::DIR_NONE;
            direction_valid <= 1'b0;
            orange_detected <= 1'b0;
            coverage_valid  <= 1'b0;
        end else begin
            direction_valid <= px.valid && px.line_end;
            coverage_valid  <= px.valid && px.frame_end;
            if (px.valid && px.line_end) begin
                direction <= dir_next;
            end
            if (px.valid && px.frame_end) begin
                orange_detected <= (total_scaled > COVER_LIMIT);
            end
        end
    end

    // A frame end is always the line end of the last row
    a_cov_with_dir: assert property (@(posedge clk) disable iff (!rst_n)
        coverage_valid |-> direction_valid);

endmodule

// ==== hdl/orange_vision_top.sv ====
`timescale 1ns/10ps

module orange_vision_top #(
    parameter int FRAME_WIDTH  = 320,
    parameter int FRAME_HEIGHT = 240,
    parameter int LEFT_END     = 100,
    parameter int RIGHT_START  = 295,
    parameter int COVERAGE_PCT = 25
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          vsync,
    input  logic                          href,
    input  orange_vision_pkg::color_t     red,
    input  orange_vision_pkg::color_t     green,
    input  orange_vision_pkg::color_t     blue,
    output orange_vision_pkg::direction_t direction,
    output logic                          direction_valid,
    output logic                          orange_detected,
    output logic                          coverage_valid
);

    pixel_stream_if trk_if ();  // Tracker to detector
    pixel_stream_if det_if ();  // Detector to classifier

    raster_tracker #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) tracker_i (
        .clk   (clk),
        .rst_n (rst_n),
        .vsync (vsync),
        .href  (href),
        .red   (red),
        .green (green),
        .blue  (blue),
        .px    (trk_if.source)
    );

    orange_color_detect detect_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_px  (trk_if.sink),
        .out_px (det_if.source)
    );

    orange_classification #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .LEFT_END     (LEFT_END),
        .RIGHT_START  (RIGHT_START),
        .COVERAGE_PCT (COVERAGE_PCT)
    ) classify_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .px              (det_if.sink),
        .direction       (direction),
        .direction_valid (direction_valid),
        .orange_detected (orange_detected),
        .coverage_valid  (coverage_valid)
    );

endmodule

// ==== testbench/orange_vision_tb.sv ====
`timescale 1ns/10ps

module orange_vision_tb;

    typedef orange_vision_pkg::color_t     color_t;
    typedef orange_vision_pkg::direction_t direction_t;

    localparam int FRAME_WIDTH  = 40;
    localparam int FRAME_HEIGHT = 6;
    localparam int LEFT_END     = 12;
    localparam int RIGHT_START  = 30;
    localparam int COVERAGE_PCT = 25;
    localparam int NUM_FRAMES   = 10;
    localparam int LINE_LIMIT   = 4 * FRAME_HEIGHT + 8;  // Lines allowed per frame
    localparam int LATENCY      = 5;  // Drive edge, sample edge, then three stages

    localparam int RED_MIN   = int'(orange_vision_pkg::ORANGE_RED_MIN);
    localparam int GREEN_MIN = int'(orange_vision_pkg::ORANGE_GREEN_MIN);
    localparam int GREEN_MAX = int'(orange_vision_pkg::ORANGE_GREEN_MAX);
    localparam int BLUE_MAX  = int'(orange_vision_pkg::ORANGE_BLUE_MAX);

    logic       clk;
    logic       rst_n;
    logic       vsync;
    logic       href;
    color_t     red;
    color_t     green;
    color_t     blue;
    direction_t direction;
    logic       direction_valid;
    logic       orange_detected;
    logic       coverage_valid;

    integer seed  = 98170;
    int     cycle = 0;

    // Reference model state
    int   m_col       = 0;
    int   m_row       = 0;
    logic m_overrun   = 1'b0;
    int   zone_left   = 0;
    int   zone_center = 0;
    int   zone_right  = 0;
    int   frame_total = 0;
    int   frames_done = 0;
    bit   seen_cov0   = 1'b0;
    bit   seen_cov1   = 1'b0;

    direction_t dir_q[$];
    int         dir_cycle_q[$];
    logic       cov_q[$];
    int         cov_cycle_q[$];

    direction_t mon_dir;
    int         mon_dir_cycle;
    logic       mon_cov;
    int         mon_cov_cycle;

    orange_vision_top #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .LEFT_END     (LEFT_END),
        .RIGHT_START  (RIGHT_START),
        .COVERAGE_PCT (COVERAGE_PCT)
    ) dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .vsync           (vsync),
        .href            (href),
        .red             (red),
        .green           (green),
        .blue            (blue),
        .direction       (direction),
        .direction_valid (direction_valid),
        .orange_detected (orange_detected),
        .coverage_valid  (coverage_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    task automatic check_direction(input direction_t exp, input direction_t got);
        if (got !== exp) begin
            $display("Fail at time %0t: direction %s, expected %s",
                     $time, got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_coverage(input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail at time %0t: orange_detected %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int exp, input int got);
        if (got != exp) begin
            $display("Fail at time %0t: strobe in cycle %0d, expected cycle %0d",
                     $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idle();
        check_flag("direction_valid", 1'b0, direction_valid);
        check_flag("coverage_valid", 1'b0, coverage_valid);
        check_direction(orange_vision_pkg::DIR_NONE, direction);
        check_coverage(1'b0, orange_detected);
    endtask

    function automatic logic is_orange_color(input color_t r, input color_t g, input color_t b);
        return (int'(r) >= RED_MIN) && (int'(g) >= GREEN_MIN) && (int'(g) <= GREEN_MAX)
            && (int'(b) <= BLUE_MAX);
    endfunction

    function automatic direction_t expected_direction(input int l, input int c, input int r);
        if (r > l) begin
            return orange_vision_pkg::DIR_RIGHT;
        end else if (c > l && c > r) begin
            return orange_vision_pkg::DIR_CENTER;
        end else if (l > r) begin
            return orange_vision_pkg::DIR_LEFT;
        end else begin
            return orange_vision_pkg::DIR_NONE;
        end
    endfunction

    // Follows one sampled input cycle through the raster and zone rules
    task automatic follow_input(input logic vs, input logic hr, input color_t r,
                                input color_t g, input color_t b, input int at_cycle);
        if (vs) begin
            m_col     = 0;
            m_row     = 0;
            m_overrun = 1'b0;
        end else if (!hr) begin
            m_col     = 0;
            m_overrun = 1'b0;
        end else if (!m_overrun) begin
            if (m_col == 0) begin
                zone_left   = 0;
                zone_center = 0;
                zone_right  = 0;
            end
            if (is_orange_color(r, g, b)) begin
                frame_total = frame_total + 1;
                if (m_col < LEFT_END) zone_left = zone_left + 1;
                else if (m_col < RIGHT_START) zone_center = zone_center + 1;
                else zone_right = zone_right + 1;
            end
            if (m_col == FRAME_WIDTH - 1) begin
                dir_q.push_back(expected_direction(zone_left, zone_center, zone_right));
                dir_cycle_q.push_back(at_cycle + LATENCY);
                if (m_row == FRAME_HEIGHT - 1) begin
                    cov_q.push_back(frame_total * 100 > COVERAGE_PCT * FRAME_WIDTH * FRAME_HEIGHT);
                    cov_cycle_q.push_back(at_cycle + LATENCY);
                    frame_total = 0;
                    frames_done = frames_done + 1;
                    m_row       = 0;
                end else begin
                    m_row = m_row + 1;
                end
                m_col     = 0;
                m_overrun = 1'b1;  // Rest of this href pulse is dropped
            end else begin
                m_col = m_col + 1;
            end
        end
    endtask

    task automatic drive_cycle(input logic vs, input logic hr, input color_t r,
                               input color_t g, input color_t b);
        @(posedge clk);
        vsync <= vs;
        href  <= hr;
        red   <= r;
        green <= g;
        blue  <= b;
        follow_input(vs, hr, r, g, b, cycle);
    endtask

    // Values on the box edges come up often
    task automatic make_pixel(input bit orange, output color_t r, output color_t g,
                              output color_t b);
        if (orange) begin
            r = color_t'(pick(2) == 0 ? RED_MIN : RED_MIN + pick(16 - RED_MIN));
            g = color_t'(pick(2) == 0 ? (pick(2) == 0 ? GREEN_MIN : GREEN_MAX)
                                      : GREEN_MIN + pick(GREEN_MAX - GREEN_MIN + 1));
            b = color_t'(pick(2) == 0 ? BLUE_MAX : pick(BLUE_MAX + 1));
        end else begin
            r = color_t'(pick(16));
            g = color_t'(pick(16));
            b = color_t'(pick(16));
            case (pick(4))  // Push one channel out of the box
                0: r = color_t'(pick(2) == 0 ? RED_MIN - 1 : pick(RED_MIN));
                1: g = color_t'(pick(2) == 0 ? GREEN_MIN - 1 : pick(GREEN_MIN));
                2: g = color_t'(pick(2) == 0 ? GREEN_MAX + 1
                                             : GREEN_MAX + 1 + pick(15 - GREEN_MAX));
                default: b = color_t'(pick(2) == 0 ? BLUE_MAX + 1
                                                   : BLUE_MAX + 1 + pick(15 - BLUE_MAX));
            endcase
        end
    endtask

    // Mode 0 uniform, 1 centre only, 2 no orange, 3 left only
    task automatic drive_line(input int length, input int mode, input int prob);
        color_t r;
        color_t g;
        color_t b;
        int     p;
        for (int c = 0; c < length; c++) begin
            case (mode)
                1: p = (c >= LEFT_END && c < RIGHT_START) ? prob : 0;
                2: p = 0;
                3: p = (c < LEFT_END) ? prob : 0;
                default: p = prob;
            endcase
            make_pixel(pick(100) < p, r, g, b);
            drive_cycle(1'b0, 1'b1, r, g, b);
        end
    endtask

    task automatic vsync_pulse();
        repeat (2) drive_cycle(1'b1, 1'b0, 4'd0, 4'd0, 4'd0);
        repeat (2) drive_cycle(1'b0, 1'b0, 4'd0, 4'd0, 4'd0);
    endtask

    task automatic run_frame(input bit heavy, input bit mid_vsync);
        int start;
        int lines;
        int len;
        start = frames_done;
        lines = 0;
        vsync_pulse();
        while (frames_done == start && lines < LINE_LIMIT) begin
            if (mid_vsync && lines == 3) vsync_pulse();  // Restart the row count
            case (pick(8))
                0: len = 1 + pick(FRAME_WIDTH - 1);      // href falls early
                1: len = FRAME_WIDTH + 1 + pick(4);      // href held past the row
                default: len = FRAME_WIDTH;
            endcase
            drive_line(len, heavy ? pick(2) : pick(4), heavy ? 85 : 10);
            repeat (pick(4)) drive_cycle(1'b0, 1'b0, 4'd0, 4'd0, 4'd0);
            lines = lines + 1;
        end
        if (frames_done == start) begin
            $display("Timed out waiting for a frame end after %0d lines", lines);
            abort_run();
        end
    endtask

    always @(negedge clk) begin
        if (direction_valid === 1'b1) begin
            if (dir_q.size() == 0) begin
                $display("Direction strobe at time %0t with no complete row driven", $time);
                abort_run();
            end else begin
                mon_dir       = dir_q.pop_front();
                mon_dir_cycle = dir_cycle_q.pop_front();
                check_direction(mon_dir, direction);
                check_latency(mon_dir_cycle, cycle);
            end
        end
    end

    always @(negedge clk) begin
        if (coverage_valid === 1'b1) begin
            if (cov_q.size() == 0) begin
                $display("Coverage strobe at time %0t with no complete frame driven", $time);
                abort_run();
            end else begin
                mon_cov       = cov_q.pop_front();
                mon_cov_cycle = cov_cycle_q.pop_front();
                check_coverage(mon_cov, orange_detected);
                check_latency(mon_cov_cycle, cycle);
                check_flag("direction_valid beside coverage_valid", 1'b1, direction_valid);
                if (mon_cov) seen_cov1 = 1'b1;
                else seen_cov0 = 1'b1;
            end
        end
    end

    initial begin
        rst_n <= 1'b0;
        vsync <= 1'b0;
        href  <= 1'b0;
        red   <= '0;
        green <= '0;
        blue  <= '0;
        @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f % 2 == 0, f == 5);  // Even frames heavy in orange
        end

        for (int n = 0; n < 50 && (dir_q.size() != 0 || cov_q.size() != 0); n++) begin
            @(posedge clk);
        end

        if (dir_q.size() != 0 || cov_q.size() != 0) begin
            $display("Timed out with %0d direction and %0d coverage results never reported",
                     dir_q.size(), cov_q.size());
            abort_run();
        end else if (!(seen_cov0 && seen_cov1)) begin
            $display("Frame coverage never reported both outcomes");
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== orange_vision.f ====
hdl/orange_vision_pkg.sv
hdl/pixel_stream_if.sv
hdl/raster_tracker.sv
hdl/orange_color_detect.sv
hdl/orange_classification.sv
hdl/orange_vision_top.sv
testbench/orange_vision_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the orange_vision testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module orange_vision_tb \
    -f orange_vision.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vorange_vision_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
